// ==== verilog/uart_pkg.sv ====
package uart_pkg;

	// mode word, bus sees raw, cores see fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [15:0] reserved;
			logic [7:0]  baud_div;    // bit period minus one
			logic [1:0]  data_len;
			logic [1:0]  stop_len;
			logic        parity_en;
			logic [1:0]  parity_type;
			logic        enable;
		} f;
	} uart_mode_u;

	localparam logic [1:0] DLEN_8 = 2'd0;
	localparam logic [1:0] DLEN_7 = 2'd1;
	localparam logic [1:0] DLEN_6 = 2'd2;
	localparam logic [1:0] DLEN_5 = 2'd3;
	localparam logic [1:0] STOP_1 = 2'd0;   // anything else is two stop bits
	localparam logic [1:0] PAR_EVEN = 2'd0;
	localparam logic [1:0] PAR_ODD  = 2'd1;
	localparam logic [1:0] PAR_ONE  = 2'd2;
	localparam logic [1:0] PAR_ZERO = 2'd3;
	localparam int MIN_BAUD_DIV = 3;

	// frame FSM states, same in both cores
	localparam logic [2:0] FS_IDLE   = 3'd0;
	localparam logic [2:0] FS_START  = 3'd1;
	localparam logic [2:0] FS_DATA   = 3'd2;
	localparam logic [2:0] FS_PARITY = 3'd3;
	localparam logic [2:0] FS_STOP   = 3'd4;

	localparam int FIFO_ADDR_BITS = 4;
	localparam int FIFO_DEPTH = 1 << FIFO_ADDR_BITS;
	localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);   // holds 0..FIFO_DEPTH

	localparam int RX_IR_THRESHOLD = 12;
	localparam int RX_TIMEOUT_CYCLES = 2048;
	localparam int TIMEOUT_BITS = $clog2(RX_TIMEOUT_CYCLES);

	localparam int BUS_ADDR_BITS = 6;
	localparam logic [BUS_ADDR_BITS-1:0] ADDR_STATUS = 0;
	localparam logic [BUS_ADDR_BITS-1:0] ADDR_COUNT  = 1;
	localparam logic [BUS_ADDR_BITS-1:0] ADDR_MODE   = 2;
	localparam logic [BUS_ADDR_BITS-1:0] ADDR_DATA   = 3;

	localparam int ST_TX_EMPTY  = 0;
	localparam int ST_RX_AVAIL  = 1;
	localparam int ST_TX_OF     = 2;
	localparam int ST_RX_UF     = 3;
	localparam int ST_RX_OF     = 4;
	localparam int ST_RX_ERR    = 5;
	localparam int ST_TX_ACTIVE = 30;
	localparam int ST_RX_BUSY   = 31;

	function automatic logic [7:0] data_mask(input logic [1:0] len);
		case (len)
			DLEN_8: return 8'hff;
			DLEN_7: return 8'h7f;
			DLEN_6: return 8'h3f;
			DLEN_5: return 8'h1f;
		endcase
	endfunction

	// expects the byte already masked to the data length
	function automatic logic parity_bit(input logic [7:0] d, input logic [1:0] ptype);
		case (ptype)
			PAR_EVEN: return ^d;
			PAR_ODD:  return ~^d;
			PAR_ONE:  return 1'b1;
			PAR_ZERO: return 1'b0;
		endcase
	endfunction

endpackage

// ==== verilog/uart_cfg_if.sv ====
interface uart_cfg_if;
	logic [7:0] baud_div;
	logic [1:0] data_len;
	logic [1:0] stop_len;
	logic       parity_en;
	logic [1:0] parity_type;
	logic       enable;

	// register block drives, both cores only listen
	modport regs (
		output baud_div, data_len, stop_len, parity_en, parity_type, enable
	);
	modport core (
		input baud_div, data_len, stop_len, parity_en, parity_type, enable
	);
endinterface

// ==== verilog/byte_fifo.sv ====
module byte_fifo #(
	parameter int ADDR_BITS = uart_pkg::FIFO_ADDR_BITS
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               clear_i,
	input  logic               push_i,
	input  logic [7:0]         din_i,
	input  logic               pop_i,
	output logic [7:0]         dout_o,
	output logic               full_o,
	output logic               empty_o,
	output logic [ADDR_BITS:0] count_o,
	output logic [ADDR_BITS:0] space_o
);

	logic [7:0]           mem [2**ADDR_BITS];
	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [ADDR_BITS:0]   count;
	logic                 wr_en;
	logic                 rd_en;

	assign wr_en = push_i & ~full_o;   // push into full is lost
	assign rd_en = pop_i & ~empty_o;

	assign dout_o = mem[rd_ptr];  // head shows without a pop
	assign full_o = count[ADDR_BITS];  // top bit only set at full depth
	assign empty_o = (count == '0);
	assign count_o = count;
	assign space_o = {1'b1, {ADDR_BITS{1'b0}}} - count;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge clk) begin
		if (rst || clear_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

endmodule

// ==== verilog/uart_tx.sv ====
module uart_tx (
	input  logic       clk,
	input  logic       rst,
	uart_cfg_if.core   cfg,
	input  logic       empty_i,
	input  logic [7:0] byte_i,
	output logic       ack_o,
	output logic       tx_o
);
	import uart_pkg::*;

	logic [2:0] state;
	logic [7:0] cnt;      // cycles into the current bit
	logic [7:0] shreg;
	logic [2:0] bit_idx;
	logic       par_q;
	logic       stop2_q;  // second stop bit still to go
	logic       line_q;
	logic       tick;
	logic       two_stop;
	logic [7:0] head_masked;

	assign tick = (cnt == cfg.baud_div);
	assign two_stop = (cfg.stop_len != STOP_1);
	assign head_masked = byte_i & data_mask(cfg.data_len);

	// head byte is latched on the same edge that pops it
	assign ack_o = (state == FS_IDLE) & cfg.enable & ~empty_i;
	assign tx_o = line_q | ~cfg.enable;  // line idles high when disabled

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FS_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			stop2_q <= 1'b0;
			line_q <= 1'b1;
		end else if (!cfg.enable) begin
			state <= FS_IDLE;
			cnt <= '0;
			line_q <= 1'b1;
		end else begin
			cnt <= tick ? 8'd0 : cnt + 8'd1;
			case (state)
				FS_IDLE: begin
					cnt <= '0;
					if (!empty_i) begin
						shreg <= head_masked;
						par_q <= parity_bit(head_masked, cfg.parity_type);
						line_q <= 1'b0;  // start bit
						state <= FS_START;
					end
				end
				FS_START: if (tick) begin
					line_q <= shreg[0];
					shreg <= shreg >> 1;
					bit_idx <= '0;
					state <= FS_DATA;
				end
				FS_DATA: if (tick) begin
					if (bit_idx == 3'd7 - cfg.data_len) begin
						stop2_q <= two_stop;
						if (cfg.parity_en) begin
							line_q <= par_q;
							state <= FS_PARITY;
						end else begin
							line_q <= 1'b1;
							state <= FS_STOP;
						end
					end else begin
						line_q <= shreg[0];  // lsb first
						shreg <= shreg >> 1;
						bit_idx <= bit_idx + 3'd1;
					end
				end
				FS_PARITY: if (tick) begin
					line_q <= 1'b1;
					state <= FS_STOP;
				end
				FS_STOP: if (tick) begin
					if (stop2_q)
						stop2_q <= 1'b0;
					else
						state <= FS_IDLE;
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/uart_rx.sv ====
module uart_rx (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_i,
	uart_cfg_if.core   cfg,
	output logic [7:0] byte_o,
	output logic       ack_o,
	output logic       err_o,
	output logic       busy_o
);
	import uart_pkg::*;

	logic       rx_s1, rx_s2, rx_q;
	logic [2:0] state;
	logic [7:0] cnt;
	logic [7:0] shreg;    // bits enter from the top
	logic [2:0] bit_idx;
	logic       par_q;    // sampled parity bit
	logic       stop_bad;
	logic       stop2_q;
	logic       tick;
	logic       half;
	logic       two_stop;
	logic [7:0] rx_data;
	logic       frame_bad;

	assign tick = (cnt == cfg.baud_div);
	assign half = (cnt == (cfg.baud_div >> 1));
	assign two_stop = (cfg.stop_len != STOP_1);
	assign rx_data = shreg >> cfg.data_len;  // align to bit 0, upper bits zero
	assign frame_bad = stop_bad | ~rx_s2
		| (cfg.parity_en & (par_q != parity_bit(rx_data, cfg.parity_type)));
	assign busy_o = (state != FS_IDLE);

	// two flop sync plus one more for edge detect
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_q <= 1'b1;
		end else begin
			rx_s1 <= rx_i;
			rx_s2 <= rx_s1;
			rx_q <= rx_s2;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FS_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			stop_bad <= 1'b0;
			stop2_q <= 1'b0;
			ack_o <= 1'b0;
			err_o <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			cnt <= tick ? 8'd0 : cnt + 8'd1;
			if (!cfg.enable) begin
				state <= FS_IDLE;
				cnt <= '0;
			end else begin
				case (state)
					FS_IDLE: begin
						cnt <= '0;
						if (rx_q && !rx_s2)
							state <= FS_START;
					end
					FS_START: begin
						cnt <= cnt + 8'd1;
						if (half) begin
							cnt <= '0;
							bit_idx <= '0;
							// line back high means a glitch
							state <= rx_s2 ? FS_IDLE : FS_DATA;
						end
					end
					FS_DATA: if (tick) begin
						shreg <= {rx_s2, shreg[7:1]};
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7 - cfg.data_len) begin
							stop_bad <= 1'b0;
							stop2_q <= two_stop;
							state <= cfg.parity_en ? FS_PARITY : FS_STOP;
						end
					end
					FS_PARITY: if (tick) begin
						par_q <= rx_s2;
						state <= FS_STOP;
					end
					FS_STOP: if (tick) begin
						if (stop2_q) begin
							stop2_q <= 1'b0;
							stop_bad <= ~rx_s2;
						end else begin
							state <= FS_IDLE;
							if (frame_bad) begin
								err_o <= 1'b1;  // byte is dropped
							end else begin
								ack_o <= 1'b1;
								byte_o <= rx_data;
							end
						end
					end
					default: state <= FS_IDLE;
				endcase
			end
		end
	end

endmodule

// ==== verilog/uart_regs.sv ====
module uart_regs (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              cs_i,
	input  logic                              we_i,
	input  logic [uart_pkg::BUS_ADDR_BITS-1:0] addr_i,
	input  logic [3:0]                        sel_i,
	input  logic [31:0]                       wdata_i,
	output logic [31:0]                       rdata_o,
	output logic                              ack_o,
	uart_cfg_if.regs                          cfg,
	output logic                              tx_push_o,
	output logic [7:0]                        tx_byte_o,
	output logic                              rx_pop_o,
	output logic                              fifo_clear_o,
	output logic                              irq_o,
	input  logic                              tx_full_i,
	input  logic                              tx_empty_i,
	input  logic [uart_pkg::CNT_BITS-1:0]     tx_space_i,
	input  logic                              rx_full_i,
	input  logic                              rx_empty_i,
	input  logic [uart_pkg::CNT_BITS-1:0]     rx_count_i,
	input  logic [7:0]                        rx_byte_i,
	input  logic                              tx_ack_i,
	input  logic                              rx_ack_i,
	input  logic                              rx_err_i,
	input  logic                              rx_busy_i
);
	import uart_pkg::*;

	uart_mode_u mode;
	logic access;
	logic data_acc;
	logic mode_wr;
	logic [31:0] status;
	logic tx_of_q, rx_uf_q, rx_of_q, rx_err_q;
	logic [CNT_BITS-1:0] rx_count_q;
	logic [TIMEOUT_BITS-1:0] idle_cnt;   // cycles with RX data and no pop
	logic ir_tx_empty, ir_rx_thr, ir_err, ir_timeout, ir_tx_of, ir_rx_of, ir_rx_uf;

	assign access = cs_i & ~ack_o;
	assign data_acc = access && (addr_i == ADDR_DATA);
	assign mode_wr = access && we_i && (addr_i == ADDR_MODE);

	// FIFOs empty on the same edge that loads the new mode
	assign fifo_clear_o = mode_wr;

	// divisors below the minimum are raised to it
	assign cfg.baud_div = (mode.f.baud_div < 8'(MIN_BAUD_DIV)) ? 8'(MIN_BAUD_DIV)
		: mode.f.baud_div;
	assign cfg.data_len = mode.f.data_len;
	assign cfg.stop_len = mode.f.stop_len;
	assign cfg.parity_en = mode.f.parity_en;
	assign cfg.parity_type = mode.f.parity_type;
	assign cfg.enable = mode.f.enable;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			tx_push_o <= 1'b0;
			rx_pop_o <= 1'b0;
			mode.raw <= '0;
		end else begin
			ack_o <= access;
			tx_push_o <= data_acc & we_i;
			rx_pop_o <= data_acc & ~we_i;   // pops during the ack cycle
			if (mode_wr) begin
				for (int i = 0; i < 4; i++)
					if (sel_i[i])
						mode.raw[8*i +: 8] <= wdata_i[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			tx_byte_o <= wdata_i[7:0];  // sel_i ignored for data
			case (addr_i)
				ADDR_STATUS: rdata_o <= status;
				ADDR_COUNT:  rdata_o <= {16'(rx_count_i), 16'(tx_space_i)};
				ADDR_MODE:   rdata_o <= mode.raw;
				ADDR_DATA:   rdata_o <= {24'h0, rx_byte_i};
				default:     rdata_o <= '0;
			endcase
		end
	end

	always_comb begin
		status = '0;
		status[ST_TX_EMPTY] = tx_empty_i;
		status[ST_RX_AVAIL] = ~rx_empty_i;
		status[ST_TX_OF] = tx_of_q;
		status[ST_RX_UF] = rx_uf_q;
		status[ST_RX_OF] = rx_of_q;
		status[ST_RX_ERR] = rx_err_q;
		status[ST_TX_ACTIVE] = mode.f.enable & ~tx_empty_i;
		status[ST_RX_BUSY] = rx_busy_i;
	end

	// event terms, each also feeds the interrupt
	assign ir_tx_of = tx_push_o & tx_full_i;
	assign ir_rx_of = rx_ack_i & rx_full_i;
	assign ir_rx_uf = rx_pop_o & rx_empty_i;
	assign ir_err = rx_err_i;
	// last byte leaving the TX FIFO
	assign ir_tx_empty = tx_ack_i & ~tx_push_o & (tx_space_i == CNT_BITS'(FIFO_DEPTH - 1));
	assign ir_rx_thr = (rx_count_i == CNT_BITS'(RX_IR_THRESHOLD))
		&& (rx_count_q != CNT_BITS'(RX_IR_THRESHOLD));
	assign ir_timeout = (idle_cnt == TIMEOUT_BITS'(RX_TIMEOUT_CYCLES - 1))
		& ~rx_empty_i & ~rx_pop_o;

	always_ff @(posedge clk) begin
		if (rst || fifo_clear_o) begin
			tx_of_q <= 1'b0;
			rx_uf_q <= 1'b0;
			rx_of_q <= 1'b0;
			rx_err_q <= 1'b0;
		end else begin
			if (ir_tx_of)
				tx_of_q <= 1'b1;
			if (ir_rx_uf)
				rx_uf_q <= 1'b1;
			if (ir_rx_of)
				rx_of_q <= 1'b1;
			if (ir_err)
				rx_err_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_count_q <= '0;
			idle_cnt <= '0;
			irq_o <= 1'b0;
		end else begin
			rx_count_q <= rx_count_i;
			if (rx_empty_i || rx_pop_o)
				idle_cnt <= '0;
			else
				idle_cnt <= idle_cnt + 1'b1;  // wraps, so the timeout repeats
			irq_o <= ir_tx_empty | ir_rx_thr | ir_err | ir_timeout
				| ir_tx_of | ir_rx_of | ir_rx_uf;
		end
	end

endmodule

// ==== verilog/wb_uart.sv ====
module wb_uart (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              rx_i,
	input  logic                              cs_i,
	input  logic                              we_i,
	input  logic [uart_pkg::BUS_ADDR_BITS-1:0] addr_i,
	input  logic [3:0]                        sel_i,
	input  logic [31:0]                       wdata_i,
	output logic [31:0]                       rdata_o,
	output logic                              ack_o,
	output logic                              tx_o,
	output logic                              irq_o
);
	import uart_pkg::*;

	logic                tx_push, tx_ack, tx_full, tx_empty;
	logic [7:0]          tx_byte, tx_head;
	logic [CNT_BITS-1:0] tx_space;
	logic                rx_ack, rx_err, rx_busy, rx_pop, rx_full, rx_empty;
	logic [7:0]          rx_byte, rx_head;
	logic [CNT_BITS-1:0] rx_count;
	logic                fifo_clear;

	uart_cfg_if cfg_if ();

	uart_regs u_regs (
		.clk(clk), .rst(rst),
		.cs_i(cs_i), .we_i(we_i), .addr_i(addr_i), .sel_i(sel_i), .wdata_i(wdata_i),
		.rdata_o(rdata_o), .ack_o(ack_o),
		.cfg(cfg_if),
		.tx_push_o(tx_push), .tx_byte_o(tx_byte), .rx_pop_o(rx_pop),
		.fifo_clear_o(fifo_clear), .irq_o(irq_o),
		.tx_full_i(tx_full), .tx_empty_i(tx_empty), .tx_space_i(tx_space),
		.rx_full_i(rx_full), .rx_empty_i(rx_empty), .rx_count_i(rx_count),
		.rx_byte_i(rx_head), .tx_ack_i(tx_ack), .rx_ack_i(rx_ack),
		.rx_err_i(rx_err), .rx_busy_i(rx_busy)
	);

	// tx_ack doubles as the FIFO pop
	byte_fifo #(.ADDR_BITS(FIFO_ADDR_BITS)) tx_fifo (
		.clk(clk), .rst(rst), .clear_i(fifo_clear),
		.push_i(tx_push), .din_i(tx_byte), .pop_i(tx_ack),
		.dout_o(tx_head), .full_o(tx_full), .empty_o(tx_empty),
		.count_o(), .space_o(tx_space)
	);

	uart_tx u_tx (
		.clk(clk), .rst(rst), .cfg(cfg_if),
		.empty_i(tx_empty), .byte_i(tx_head), .ack_o(tx_ack), .tx_o(tx_o)
	);

	uart_rx u_rx (
		.clk(clk), .rst(rst), .rx_i(rx_i), .cfg(cfg_if),
		.byte_o(rx_byte), .ack_o(rx_ack), .err_o(rx_err), .busy_o(rx_busy)
	);

	byte_fifo #(.ADDR_BITS(FIFO_ADDR_BITS)) rx_fifo (
		.clk(clk), .rst(rst), .clear_i(fifo_clear),
		.push_i(rx_ack), .din_i(rx_byte), .pop_i(rx_pop),
		.dout_o(rx_head), .full_o(rx_full), .empty_o(rx_empty),
		.count_o(rx_count), .space_o()
	);

endmodule

// ==== sim/wb_uart_assert.sv ====
module wb_uart_assert (
	input logic clk,
	input logic rst,
	input logic ack_i,
	input logic tx_i,
	input logic enable_i,
	input logic tx_push_i,
	input logic tx_full_i,
	input logic tx_of_i
);

	int fail_count = 0;   // read by the testbench at the end

	// one access gives exactly one ack cycle
	a_ack_single: assert property (@(posedge clk) disable iff (rst) ack_i |=> !ack_i)
		else begin
			$error("ack_o stayed high for two cycles");
			fail_count++;
		end

	a_line_idle: assert property (@(posedge clk) disable iff (rst) !enable_i |-> tx_i)
		else begin
			$error("tx_o low while the transmitter is disabled");
			fail_count++;
		end

	// a dropped push must show up as overflow
	a_push_full: assert property (@(posedge clk) disable iff (rst)
		(tx_push_i && tx_full_i) |=> tx_of_i)
		else begin
			$error("push into full TX FIFO without overflow flag");
			fail_count++;
		end

endmodule

bind wb_uart wb_uart_assert u_assert (
	.clk(clk), .rst(rst), .ack_i(ack_o), .tx_i(tx_o),
	.enable_i(cfg_if.enable), .tx_push_i(tx_push), .tx_full_i(tx_full),
	.tx_of_i(u_regs.tx_of_q)
);

// ==== sim/tb_wb_uart.sv ====
module tb_wb_uart;
	import uart_pkg::*;

	localparam int BIT_CYCLES = 8;   // baud_div 7 in every test
	// all frames of all tests, in bits, plus the timeout test and bus traffic
	localparam int WATCHDOG_CYCLES = (22 * 10 + 4 * 11 + 4 * 8 + 11 + 10) * BIT_CYCLES
		+ RX_TIMEOUT_CYCLES + 4 + 3000;

	logic clk;
	logic rst;
	logic cs, we;
	logic [BUS_ADDR_BITS-1:0] addr;
	logic [3:0] sel;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic ack, tx_o, irq;
	logic loop, rx_drv;
	wire rx_line;

	logic [31:0] lfsr = 32'h2910;
	logic [31:0] cur_mode;
	logic [7:0] sent_q[$];    // bytes still to be read back
	logic [7:0] exp_q[$];     // bytes still to be seen on tx_o
	logic [31:0] exp_mode_q[$];
	logic [11:0] seen_q[$];
	int checks = 0;
	int errors = 0;
	int err_base;
	int irq_count = 0;
	int base;
	int n;
	logic [31:0] rd;
	logic [11:0] bad_frame;

	assign rx_line = loop ? tx_o : rx_drv;

	wb_uart dut (
		.clk(clk), .rst(rst), .rx_i(rx_line),
		.cs_i(cs), .we_i(we), .addr_i(addr), .sel_i(sel), .wdata_i(wdata),
		.rdata_o(rdata), .ack_o(ack), .tx_o(tx_o), .irq_o(irq)
	);

	always #20 clk = ~clk;

	always @(negedge clk)
		if (!rst && irq === 1'b1)
			irq_count++;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	function automatic logic [31:0] make_mode(input logic [7:0] div, input logic [1:0] dlen,
		input logic [1:0] stop, input logic pen, input logic [1:0] ptype, input logic en);
		return {16'h0, div, dlen, stop, pen, ptype, en};
	endfunction

	function automatic logic [7:0] data_bits(input logic [7:0] d, input logic [31:0] m);
		logic [7:0] r;
		int nd;
		nd = 8 - int'(m[7:6]);
		r = '0;
		for (int k = 0; k < nd; k++)
			r[k] = d[k];
		return r;
	endfunction

	function automatic int frame_len(input logic [31:0] m);
		return 1 + (8 - int'(m[7:6])) + int'(m[3]) + ((m[5:4] != 2'd0) ? 2 : 1);
	endfunction

	// line bits in send order, bit 0 is the start bit
	function automatic logic [11:0] frame_bits(input logic [7:0] d, input logic [31:0] m);
		logic [7:0] md;
		logic par;
		logic [11:0] b;
		int nd;
		nd = 8 - int'(m[7:6]);
		md = data_bits(d, m);
		case (m[2:1])
			2'd0: par = ^md;    // even count of ones overall
			2'd1: par = ~^md;
			2'd2: par = 1'b1;
			default: par = 1'b0;
		endcase
		b = '1;   // stop bits and unused tail
		b[0] = 1'b0;
		for (int k = 0; k < nd; k++)
			b[1 + k] = md[k];
		if (m[3])
			b[1 + nd] = par;
		return b;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic bus_access(input logic w, input logic [BUS_ADDR_BITS-1:0] a,
		input logic [31:0] d, output logic [31:0] r);
		int cnt;
		@(negedge clk);
		cs = 1'b1;
		we = w;
		addr = a;
		sel = 4'hf;
		wdata = d;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (ack !== 1'b1 && cnt < 8);
		if (ack !== 1'b1) begin
			errors++;
			$display("no acknowledge from the DUT for address %0d at %0t", a, $time);
		end
		r = rdata;
		cs = 1'b0;   // dropped in the ack cycle
		we = 1'b0;
	endtask

	task automatic bus_write(input logic [BUS_ADDR_BITS-1:0] a, input logic [31:0] d);
		logic [31:0] unused;
		bus_access(1'b1, a, d, unused);
	endtask

	task automatic bus_read(input logic [BUS_ADDR_BITS-1:0] a, output logic [31:0] r);
		bus_access(1'b0, a, 32'h0, r);
	endtask

	task automatic set_mode(input logic [31:0] m);
		bus_write(ADDR_MODE, m);
		cur_mode = m;
	endtask

	task automatic send_bytes(input int cnt);
		logic [7:0] b;
		for (int i = 0; i < cnt; i++) begin
			b = rand_byte();
			sent_q.push_back(b);
			exp_q.push_back(b);
			exp_mode_q.push_back(cur_mode);
			bus_write(ADDR_DATA, {24'h0, b});
		end
	endtask

	task automatic read_back(input int cnt);
		logic [31:0] r;
		logic [7:0] b;
		for (int i = 0; i < cnt; i++) begin
			bus_read(ADDR_DATA, r);
			b = sent_q.pop_front();
			check(r, {24'h0, data_bits(b, cur_mode)}, "received byte");
		end
	endtask

	task automatic wait_rx_count(input int cnt);
		logic [31:0] r;
		int polls;
		polls = 0;
		do begin
			bus_read(ADDR_COUNT, r);
			polls++;
		end while (r[31:16] != cnt && polls < 1000);
		if (r[31:16] != cnt) begin
			errors++;
			$display("timed out waiting for %0d received bytes at %0t", cnt, $time);
		end
	endtask

	task automatic wait_status_bit(input int pos);
		logic [31:0] r;
		int polls;
		polls = 0;
		do begin
			bus_read(ADDR_STATUS, r);
			polls++;
		end while (!r[pos] && polls < 200);
		if (!r[pos]) begin
			errors++;
			$display("timed out waiting for status bit %0d at %0t", pos, $time);
		end
	endtask

	task automatic drive_frame(input logic [11:0] bits, input int len);
		@(negedge clk);
		for (int k = 0; k < len; k++) begin
			rx_drv = bits[k];
			repeat (int'(cur_mode[15:8]) + 1) @(negedge clk);
		end
		rx_drv = 1'b1;
	endtask

	task automatic settle();
		repeat (4) @(posedge clk);
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s done, %0d errors", num, name, errors - err_base);
		err_base = errors;
	endtask

	// samples tx_o in the middle of each bit of a frame
	initial begin : tx_monitor
		logic [11:0] seen;
		int len;
		int per;
		forever begin
			do @(negedge clk); while (tx_o !== 1'b1);
			do @(negedge clk); while (tx_o !== 1'b0);
			len = frame_len(cur_mode);
			per = int'(cur_mode[15:8]) + 1;
			seen = '1;
			repeat (per / 2) @(negedge clk);
			for (int k = 0; k < len; k++) begin
				seen[k] = tx_o;
				if (k < len - 1)
					repeat (per) @(negedge clk);
			end
			seen_q.push_back(seen);
		end
	end

	initial begin : frame_compare
		logic [11:0] seen;
		logic [7:0] b;
		logic [31:0] m;
		forever begin
			@(posedge clk);
			if (seen_q.size() > 0) begin
				seen = seen_q.pop_front();
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected frame on tx_o at %0t", $time);
				end else begin
					b = exp_q.pop_front();
					m = exp_mode_q.pop_front();
					check(seen, frame_bits(b, m), "frame on tx_o");
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * 40);
		$display("watchdog expired, the simulation did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cs = 1'b0;
		we = 1'b0;
		addr = '0;
		sel = '0;
		wdata = '0;
		loop = 1'b1;
		rx_drv = 1'b1;
		cur_mode = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		err_base = 0;

		bus_read(ADDR_STATUS, rd);
		check(rd, 32'h1 << ST_TX_EMPTY, "status after reset");
		bus_read(ADDR_COUNT, rd);
		check(rd, {16'd0, 16'd16}, "count after reset");
		bus_read(ADDR_MODE, rd);
		check(rd, 32'h0, "mode after reset");
		check(irq, 1'b0, "irq after reset");
		end_test(1, "reset values");

		set_mode(make_mode(8'd7, 2'd0, 2'd0, 1'b0, 2'd0, 1'b1));
		send_bytes(10);
		settle();
		base = irq_count;
		wait_rx_count(10);
		settle();
		check(irq_count - base, 1, "interrupt when TX FIFO empties");
		read_back(10);
		send_bytes(12);
		settle();
		base = irq_count;
		wait_rx_count(12);
		settle();
		check(irq_count - base, 2, "TX empty and RX threshold interrupts");
		read_back(12);
		end_test(2, "8N1 loopback");

		set_mode(make_mode(8'd7, 2'd1, 2'd1, 1'b1, 2'd1, 1'b1));  // 7 bits odd two stops
		send_bytes(4);
		wait_rx_count(4);
		read_back(4);
		set_mode(make_mode(8'd7, 2'd3, 2'd0, 1'b1, 2'd0, 1'b1));  // 5 bits even
		send_bytes(4);
		wait_rx_count(4);
		read_back(4);
		end_test(3, "other formats");

		@(negedge clk);
		loop = 1'b0;
		set_mode(make_mode(8'd7, 2'd0, 2'd0, 1'b1, 2'd0, 1'b1));
		settle();
		base = irq_count;
		bad_frame = frame_bits(rand_byte(), cur_mode);
		bad_frame[9] = ~bad_frame[9];   // parity follows 8 data bits
		drive_frame(bad_frame, frame_len(cur_mode));
		wait_status_bit(ST_RX_ERR);
		settle();
		check(irq_count - base, 1, "interrupt on receive error");
		bus_read(ADDR_COUNT, rd);
		check(rd[31:16], 0, "RX count after bad frame");
		set_mode(cur_mode);
		bus_read(ADDR_STATUS, rd);
		check(rd[ST_RX_ERR], 1'b0, "error flag after mode write");
		@(negedge clk);
		loop = 1'b1;
		end_test(4, "receive error");

		set_mode(make_mode(8'd7, 2'd0, 2'd0, 1'b0, 2'd0, 1'b0));
		for (int i = 0; i < 17; i++)
			bus_write(ADDR_DATA, {24'h0, rand_byte()});
		bus_read(ADDR_COUNT, rd);
		check(rd[15:0], 0, "TX space after 17 writes");
		bus_read(ADDR_STATUS, rd);
		check(rd[ST_TX_OF], 1'b1, "TX overflow flag");
		bus_read(ADDR_DATA, rd);   // RX FIFO is empty here
		bus_read(ADDR_STATUS, rd);
		check(rd[ST_RX_UF], 1'b1, "RX underflow flag");
		set_mode(make_mode(8'd7, 2'd0, 2'd0, 1'b0, 2'd0, 1'b1));
		send_bytes(1);
		wait_rx_count(1);
		@(posedge clk);
		base = irq_count;
		n = 0;
		while (irq_count == base && n < RX_TIMEOUT_CYCLES + 4) begin
			@(posedge clk);
			n++;
		end
		check(irq_count != base, 1'b1, "RX timeout interrupt");
		read_back(1);
		end_test(5, "overflow and underflow");

		settle();
		check(exp_q.size(), 0, "frames never seen on tx_o");
		errors += dut.u_assert.fail_count;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
verilog/uart_pkg.sv
verilog/uart_cfg_if.sv
verilog/byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/wb_uart.sv
sim/wb_uart_assert.sv
sim/tb_wb_uart.sv

// ==== Bender.yml ====
package:
  name: wb_uart

sources:
  - verilog/uart_pkg.sv
  - verilog/uart_cfg_if.sv
  - verilog/byte_fifo.sv
  - verilog/uart_tx.sv
  - verilog/uart_rx.sv
  - verilog/uart_regs.sv
  - verilog/wb_uart.sv
  - target: test
    files:
      - sim/wb_uart_assert.sv
      - sim/tb_wb_uart.sv
